// File: hw/rx_engine_pkg.sv
/*
 Shared widths, request codes and stage structs of the completer-request
 receive engine. Each RTL module imports what it needs from here.
*/
package rx_engine_pkg;

   localparam int DW_BITS  = 32;  // one doubleword
   localparam int BEAT_DW  = 8;   // dws per 256-bit beat
   localparam int LEN_BITS = 11;  // dword count field

   // request type codes, descriptor bits 78:75
   localparam logic [3:0] REQ_MEM_RD = 4'b0000;
   localparam logic [3:0] REQ_MEM_WR = 4'b0001;

   ////////////////////////////////////////////////////////////
   // completer request descriptor, low 128 bits of first beat
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic                rsvd_127;
      logic [2:0]          attr;          // 126:124
      logic [2:0]          tc;            // 123:121
      logic [8:0]          bar;           // aperture and bar id
      logic [7:0]          rsvd_func;     // target function, unused
      logic [7:0]          tag;           // 103:96
      logic [15:0]         requester_id;  // 95:80
      logic                rsvd_79;
      logic [3:0]          req_type;      // 78:75
      logic [LEN_BITS-1:0] dw_count;      // 74:64
      logic [63:0]         address;       // bits 1:0 carry the AT field
   } cq_desc_t;

   // first beat view, descriptor below and payload dw0..3 above
   typedef struct packed {
      logic [3:0][DW_BITS-1:0] payload;
      cq_desc_t                desc;
   } cq_hdr_beat_t;

   // same word, read as header beat or as plain payload beat
   typedef union packed {
      cq_hdr_beat_t                   hdr;
      logic [BEAT_DW-1:0][DW_BITS-1:0] dw;   // dw[0] in bits 31:0
   } cq_beat_u;

   typedef struct packed {
      cq_beat_u   beat;
      logic       last;
      logic [7:0] byte_en;   // last dw be 7:4, first dw be 3:0
   } cq_in_t;

   typedef struct packed {
      cq_beat_u   beat;
      logic       sop;
      logic       last;
      logic [7:0] byte_en;
   } cap_beat_t;

   typedef struct packed {
      cq_beat_u            beat;
      logic                sop;
      logic                last;
      logic [LEN_BITS-1:0] len;   // only meaningful with sop
   } wr_beat_t;

   typedef struct packed {
      logic [2:0]  tc;
      logic [2:0]  attr;
      logic [9:0]  len;
      logic [15:0] requester_id;
      logic [7:0]  tag;
      logic [7:0]  byte_en;
      logic [10:0] addr;   // dw address
   } cpl_req_t;

endpackage

// File: hw/cq_beat_capture.sv
/*
 Input stage on the completer-request stream. Registers every transferred
 beat with a start-of-packet flag and holds it while the decoder stalls.
*/
module cq_beat_capture (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     cq_valid_i,
   input  rx_engine_pkg::cq_in_t    cq_i,
   output logic                     cq_ready_o,
   input  logic                     dec_ready_i,
   output logic                     cap_valid_o,
   output rx_engine_pkg::cap_beat_t cap_beat_o
);
   import rx_engine_pkg::*;

   logic in_pkt_q;   // inside a packet, first beat already seen
   logic take;       // stream transfer this cycle

   // free slot, or the held beat leaves this cycle
   assign cq_ready_o = !cap_valid_o || dec_ready_i;
   assign take       = cq_valid_i && cq_ready_o;

   ////////////////////////////////////////////////////////////
   // framing and occupancy
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt_q    <= 1'b0;
         cap_valid_o <= 1'b0;
      end else begin
         if (take) begin
            in_pkt_q <= !cq_i.last;   // last closes, first opens
         end
         if (take) begin
            cap_valid_o <= 1'b1;
         end else if (dec_ready_i) begin
            cap_valid_o <= 1'b0;      // consumed, nothing new
         end
      end
   end

   // beat register, loads on the transfer clock
   always_ff @(posedge clk) begin
      if (take) begin
         cap_beat_o.beat    <= cq_i.beat;
         cap_beat_o.sop     <= !in_pkt_q;
         cap_beat_o.last    <= cq_i.last;
         cap_beat_o.byte_en <= cq_i.byte_en;
      end
   end

endmodule

// File: hw/cq_request_decoder.sv
/*
 Request decoder. Classifies each packet from its descriptor, issues a
 four-phase completion request for one-DW reads and forwards write beats.
 Any other packet is swallowed.
*/
module cq_request_decoder (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     cap_valid_i,
   input  rx_engine_pkg::cap_beat_t cap_beat_i,
   output logic                     dec_ready_o,
   output rx_engine_pkg::cpl_req_t  cpl_req_o,
   output logic                     cpl_req_valid_o,
   input  logic                     cpl_ack_i,
   output logic                     wr_valid_o,
   output rx_engine_pkg::wr_beat_t  wr_beat_o
);
   import rx_engine_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,      // taking beats
      ST_REQ,       // req high, waiting for ack
      ST_ACK_LOW    // req dropped, waiting for ack to fall
   } cpl_state_e;

   cpl_state_e state_q;
   logic       pkt_is_wr_q;   // class of the current packet
   cq_desc_t   desc;
   logic       take;
   logic       is_rd1;        // single-dw memory read
   logic       is_wr_sop;
   logic       fwd;           // beat goes to the packer

   assign desc = cap_beat_i.beat.hdr.desc;   // only valid on sop beats

   // stall from read acceptance until ack has fallen
   assign dec_ready_o = (state_q == ST_IDLE);
   assign take        = cap_valid_i && dec_ready_o;

   assign is_rd1    = cap_beat_i.sop && (desc.req_type == REQ_MEM_RD)
                      && (desc.dw_count == LEN_BITS'(1));
   assign is_wr_sop = cap_beat_i.sop && (desc.req_type == REQ_MEM_WR);
   assign fwd       = cap_beat_i.sop ? is_wr_sop : pkt_is_wr_q;

   ////////////////////////////////////////////////////////////
   // completion handshake and packet class
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q         <= ST_IDLE;
         pkt_is_wr_q     <= 1'b0;
         cpl_req_valid_o <= 1'b0;
         wr_valid_o      <= 1'b0;
      end else begin
         wr_valid_o <= take && fwd;
         if (take && cap_beat_i.sop) begin
            pkt_is_wr_q <= is_wr_sop;   // later beats follow the header
         end
         case (state_q)
            ST_IDLE: begin
               if (take && is_rd1) begin
                  cpl_req_valid_o <= 1'b1;
                  state_q         <= ST_REQ;
               end
            end
            ST_REQ: begin
               if (cpl_ack_i) begin
                  cpl_req_valid_o <= 1'b0;   // phase 3
                  state_q         <= ST_ACK_LOW;
               end
            end
            ST_ACK_LOW: begin
               if (!cpl_ack_i) begin
                  state_q <= ST_IDLE;        // phase 4 seen
               end
            end
            default: begin
               cpl_req_valid_o <= 1'b0;
               state_q         <= ST_IDLE;
            end
         endcase
      end
   end

   // request fields, frozen while req is up
   always_ff @(posedge clk) begin
      if (take && is_rd1 && (state_q == ST_IDLE)) begin
         cpl_req_o.tc           <= desc.tc;
         cpl_req_o.attr         <= desc.attr;
         cpl_req_o.len          <= desc.dw_count[9:0];
         cpl_req_o.requester_id <= desc.requester_id;
         cpl_req_o.tag          <= desc.tag;
         cpl_req_o.byte_en      <= cap_beat_i.byte_en;
         cpl_req_o.addr         <= desc.address[12:2];   // byte to dw address
      end
   end

   // write beat toward the packer
   always_ff @(posedge clk) begin
      if (take) begin
         wr_beat_o.beat <= cap_beat_i.beat;
         wr_beat_o.sop  <= cap_beat_i.sop;
         wr_beat_o.last <= cap_beat_i.last;
         wr_beat_o.len  <= desc.dw_count;
      end
   end

endmodule

// File: hw/cq_payload_packer.sv
/*
 Write payload packer. The first beat carries only four payload DWs, so
 each FIFO word joins the upper half of one beat with the lower half of
 the next. DWs past the write length are zeroed; a leftover half is flushed.
*/
module cq_payload_packer (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    wr_valid_i,
   input  rx_engine_pkg::wr_beat_t wr_beat_i,
   output logic                    fifo_wr_o,
   output logic [255:0]            fifo_data_o
);
   import rx_engine_pkg::*;

   logic [3:0][DW_BITS-1:0] carry_q;   // upper half of the previous beat
   logic [LEN_BITS-1:0]     rem_q;     // dws not yet written incl. carry
   logic                    hold_v_q;  // second word waiting for the port
   logic [255:0]            hold_q;
   logic                    gen_a;     // word from this beat
   logic                    gen_b;     // flush word from this beat
   logic [255:0]            word_a;
   logic [255:0]            word_b;
   logic [3:0]              n_main;    // dws valid in word_a
   logic [LEN_BITS-1:0]     rem_after;

   // zero every dw at index n and above
   function automatic logic [255:0] keep_dw(
      input logic [BEAT_DW-1:0][DW_BITS-1:0] w,
      input logic [3:0]                      n
   );
      logic [BEAT_DW-1:0][DW_BITS-1:0] r;
      for (int i = 0; i < BEAT_DW; i++) begin
         r[i] = (i < n) ? w[i] : '0;
      end
      return r;
   endfunction

   ////////////////////////////////////////////////////////////
   // word assembly
   ////////////////////////////////////////////////////////////
   always_comb begin
      n_main    = (rem_q > LEN_BITS'(8)) ? 4'd8 : rem_q[3:0];
      rem_after = rem_q - LEN_BITS'(n_main);
      word_a    = keep_dw({wr_beat_i.beat.dw[3:0], carry_q}, n_main);
      word_b    = keep_dw({128'b0, wr_beat_i.beat.dw[7:4]}, rem_after[3:0]);
      gen_a     = 1'b0;
      gen_b     = 1'b0;
      if (wr_valid_i) begin
         if (wr_beat_i.sop) begin
            // short write fits entirely in the header beat
            word_a = keep_dw({128'b0, wr_beat_i.beat.hdr.payload}, wr_beat_i.len[3:0]);
            gen_a  = (wr_beat_i.len <= LEN_BITS'(4));
         end else begin
            gen_a = (rem_q != '0);
            gen_b = wr_beat_i.last && (rem_after != '0);   // leftover upper half
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rem_q     <= '0;
         hold_v_q  <= 1'b0;
         fifo_wr_o <= 1'b0;
      end else begin
         if (wr_valid_i) begin
            if (wr_beat_i.sop) begin
               rem_q <= (wr_beat_i.len <= LEN_BITS'(4)) ? '0 : wr_beat_i.len;
            end else if (wr_beat_i.last) begin
               rem_q <= '0;          // any rest leaves through the hold word
            end else begin
               rem_q <= rem_after;
            end
         end
         if (hold_v_q) begin
            fifo_wr_o <= 1'b1;       // older word first
            hold_v_q  <= gen_a;
         end else begin
            fifo_wr_o <= gen_a;
            hold_v_q  <= gen_b;
         end
      end
   end

   // payload path
   always_ff @(posedge clk) begin
      if (wr_valid_i) begin
         carry_q <= wr_beat_i.beat.dw[7:4];   // upper half of every beat
      end
      if (hold_v_q) begin
         fifo_data_o <= hold_q;
         if (gen_a) begin
            hold_q <= word_a;
         end
      end else begin
         fifo_data_o <= word_a;
         if (gen_b) begin
            hold_q <= word_b;
         end
      end
   end

endmodule

// File: hw/rx_throughput_meter.sv
/*
 Throughput meter. Counts FIFO writes over a fixed window of cycles and
 presents the count with a one-cycle strobe at the end of every window.
*/
module rx_throughput_meter #(
   parameter int unsigned WINDOW_CYCLES = 25_000_000   // cycles per window
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        fifo_wr_i,
   output logic        tput_valid_o,
   output logic [31:0] tput_count_o
);

   logic [31:0] win_cnt_q;    // position inside the window
   logic [31:0] word_cnt_q;   // words so far, this cycle excluded
   logic        win_end;

   assign win_end = (win_cnt_q == 32'(WINDOW_CYCLES - 1));

   // count covers the strobe cycle too
   assign tput_valid_o = win_end;
   assign tput_count_o = word_cnt_q + 32'(fifo_wr_i);

   ////////////////////////////////////////////////////////////
   // window and word counters
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         win_cnt_q  <= '0;
         word_cnt_q <= '0;
      end else if (win_end) begin
         win_cnt_q  <= '0;          // restart, count already published
         word_cnt_q <= '0;
      end else begin
         win_cnt_q  <= win_cnt_q + 32'd1;
         word_cnt_q <= tput_count_o;
      end
   end

endmodule

// File: hw/rx_engine.sv
/*
 Completer-request receive engine, top level. Chains capture, decoder,
 payload packer and throughput meter; WINDOW_CYCLES sets the meter window.
*/
module rx_engine #(
   parameter int unsigned WINDOW_CYCLES = 25_000_000
) (
   input  logic                    clk,
   input  logic                    rst_n,
   // completer request stream
   input  logic                    cq_valid_i,
   input  rx_engine_pkg::cq_in_t   cq_i,
   output logic                    cq_ready_o,
   // completion request to the transmit unit
   output rx_engine_pkg::cpl_req_t cpl_req_o,
   output logic                    cpl_req_valid_o,
   input  logic                    cpl_ack_i,
   // receive fifo, no back-pressure
   output logic                    fifo_wr_o,
   output logic [255:0]            fifo_data_o,
   // throughput report
   output logic                    tput_valid_o,
   output logic [31:0]             tput_count_o
);
   import rx_engine_pkg::*;

   logic      cap_valid;
   cap_beat_t cap_beat;
   logic      dec_ready;
   logic      wr_valid;
   wr_beat_t  wr_beat;

   cq_beat_capture capture_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .cq_valid_i  (cq_valid_i),
      .cq_i        (cq_i),
      .cq_ready_o  (cq_ready_o),
      .dec_ready_i (dec_ready),
      .cap_valid_o (cap_valid),
      .cap_beat_o  (cap_beat)
   );

   cq_request_decoder decoder_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .cap_valid_i     (cap_valid),
      .cap_beat_i      (cap_beat),
      .dec_ready_o     (dec_ready),
      .cpl_req_o       (cpl_req_o),
      .cpl_req_valid_o (cpl_req_valid_o),
      .cpl_ack_i       (cpl_ack_i),
      .wr_valid_o      (wr_valid),
      .wr_beat_o       (wr_beat)
   );

   cq_payload_packer packer_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr_valid_i  (wr_valid),
      .wr_beat_i   (wr_beat),
      .fifo_wr_o   (fifo_wr_o),
      .fifo_data_o (fifo_data_o)
   );

   rx_throughput_meter #(
      .WINDOW_CYCLES (WINDOW_CYCLES)
   ) meter_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .fifo_wr_i    (fifo_wr_o),
      .tput_valid_o (tput_valid_o),
      .tput_count_o (tput_count_o)
   );

endmodule

// File: verif/rx_engine_checker.sv
/*
 Concurrent assertions on the completion handshake and the stream ready
 rule. Bound into the receive engine top level from the testbench.
*/
module rx_engine_checker (
   input logic                    clk,
   input logic                    rst_n,
   input logic                    cq_ready_i,
   input logic                    cpl_req_valid_i,
   input rx_engine_pkg::cpl_req_t cpl_req_i,
   input logic                    cpl_ack_i
);
   timeunit 1ns;
   timeprecision 1ps;

   ////////////////////////////////////////////////////////////
   // completion handshake
   ////////////////////////////////////////////////////////////
   // phase 1 holds until ack, fields frozen
   req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      cpl_req_valid_i && !cpl_ack_i |=> cpl_req_valid_i && $stable(cpl_req_i))
      else $error("completion request dropped or changed before ack");

   // no new request while the old ack is still up
   req_after_ack_a: assert property (@(posedge clk) disable iff (!rst_n)
      cpl_ack_i && !cpl_req_valid_i |=> !cpl_req_valid_i)
      else $error("completion request raised while ack still high");

   ////////////////////////////////////////////////////////////
   // stream back-pressure
   ////////////////////////////////////////////////////////////
   // ready only drops from read take until ack has fallen
   ready_stall_a: assert property (@(posedge clk) disable iff (!rst_n)
      !cq_ready_i |-> cpl_req_valid_i || cpl_ack_i || $past(cpl_ack_i))
      else $error("stream stalled with no completion pending");

endmodule

// File: verif/tb_rx_engine.sv
/*
 Testbench for the receive engine. Sends random writes, one-DW reads and
 unsupported requests, acks completions with random delays and checks
 FIFO words, completion fields and throughput reports.
*/
module tb_rx_engine;
   timeunit 1ns;
   timeprecision 1ps;
   import rx_engine_pkg::*;

   localparam int WINDOW = 64;
   localparam int N_RD   = 6;   // read + write pairs
   localparam int N_MIX  = 30;
   localparam int N_PKT  = 4 + 16 + 2 * N_RD + 4 + N_MIX;
   localparam logic [3:0] REQ_OTHER = 4'b0010;   // io read is unsupported

   logic         clk = 1'b0;
   logic         rst_n;
   logic         cq_valid;
   cq_in_t       cq;
   logic         cq_ready;
   cpl_req_t     cpl_req;
   logic         cpl_req_valid;
   logic         cpl_ack;
   logic         fifo_wr;
   logic [255:0] fifo_data;
   logic         tput_valid;
   logic [31:0]  tput_count;

   logic [15:0]  lfsr = 16'd12383;
   logic [255:0] fifo_exp_q[$];   // expected fifo words in order
   cpl_req_t     cpl_exp_q[$];
   int           errors = 0;
   int           checks = 0;
   int           cyc_in_win = 0;
   logic [31:0]  words_in_win = '0;
   logic         req_prev = 1'b0;

   rx_engine #(.WINDOW_CYCLES(WINDOW)) rx_engine_i (
      .clk (clk), .rst_n (rst_n),
      .cq_valid_i (cq_valid), .cq_i (cq), .cq_ready_o (cq_ready),
      .cpl_req_o (cpl_req), .cpl_req_valid_o (cpl_req_valid), .cpl_ack_i (cpl_ack),
      .fifo_wr_o (fifo_wr), .fifo_data_o (fifo_data),
      .tput_valid_o (tput_valid), .tput_count_o (tput_count)
   );

   bind rx_engine rx_engine_checker checker_i (
      .clk (clk), .rst_n (rst_n), .cq_ready_i (cq_ready_o),
      .cpl_req_valid_i (cpl_req_valid_o), .cpl_req_i (cpl_req_o), .cpl_ack_i (cpl_ack_i)
   );

   always #5 clk = !clk;

   // galois lfsr with taps 16 14 13 11 stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return r;
   endfunction

   // fifo word w of a write with dw0 lowest and zeros past the length
   function automatic logic [255:0] ref_fifo_word(input logic [31:0] pay [48],
                                                  input int len, input int w);
      logic [255:0] r;
      r = '0;
      for (int i = 0; i < 8; i++) begin
         if (w * 8 + i < len) r[i*32 +: 32] = pay[w*8 + i];
      end
      return r;
   endfunction

   task automatic report_err(input string name, input logic [255:0] exp,
                             input logic [255:0] got);
      errors++;
      $display("ERR %s exp %h got %h", name, exp, got);
   endtask

   task automatic check_cpl(input cpl_req_t got, input cpl_req_t exp);
      checks++;
      if (got.tc !== exp.tc) report_err("cpl_req_o.tc", 256'(exp.tc), 256'(got.tc));
      if (got.attr !== exp.attr) report_err("cpl_req_o.attr", 256'(exp.attr), 256'(got.attr));
      if (got.len !== exp.len) report_err("cpl_req_o.len", 256'(exp.len), 256'(got.len));
      if (got.requester_id !== exp.requester_id)
         report_err("cpl_req_o.requester_id", 256'(exp.requester_id), 256'(got.requester_id));
      if (got.tag !== exp.tag) report_err("cpl_req_o.tag", 256'(exp.tag), 256'(got.tag));
      if (got.byte_en !== exp.byte_en)
         report_err("cpl_req_o.byte_en", 256'(exp.byte_en), 256'(got.byte_en));
      if (got.addr !== exp.addr) report_err("cpl_req_o.addr", 256'(exp.addr), 256'(got.addr));
   endtask

   // one beat held until the engine takes it
   task automatic send_beat(input cq_beat_u b, input logic last, input logic [7:0] be);
      @(negedge clk);
      cq_valid   = 1'b1;
      cq.beat    = b;
      cq.last    = last;
      cq.byte_en = be;
      @(posedge clk);
      while (!cq_ready) @(posedge clk);
   endtask

   ////////////////////////////////////////////////////////////
   // packet builder that records what the engine must produce
   ////////////////////////////////////////////////////////////
   task automatic send_packet(input logic [3:0] typ, input int len, input int n_pay);
      cq_desc_t    d;
      cq_beat_u    b;
      cpl_req_t    c;
      logic [31:0] pay [48];
      logic [29:0] dw_addr;
      logic [7:0]  be;
      int          n_beats;
      int          gap;
      for (int i = 0; i < 48; i++) pay[i] = rand_bits(32);   // dws past len are junk
      d                 = '0;
      d.address[63:32]  = rand_bits(32);
      dw_addr           = 30'(rand_bits(30));
      d.address[31:0]   = {dw_addr, 2'b00};
      d.dw_count        = LEN_BITS'(len);
      d.req_type        = typ;
      d.requester_id    = 16'(rand_bits(16));
      d.tag             = 8'(rand_bits(8));
      d.tc              = 3'(rand_bits(3));
      d.attr            = 3'(rand_bits(3));
      d.bar             = 9'(rand_bits(9));
      be                = 8'(rand_bits(8));
      n_beats = (n_pay <= 4) ? 1 : 1 + (n_pay - 4 + 7) / 8;
      if (typ == REQ_MEM_WR) begin
         for (int w = 0; w < (len + 7) / 8; w++) fifo_exp_q.push_back(ref_fifo_word(pay, len, w));
      end
      if (typ == REQ_MEM_RD && len == 1) begin
         c.tc           = d.tc;
         c.attr         = d.attr;
         c.len          = 10'(len);
         c.requester_id = d.requester_id;
         c.tag          = d.tag;
         c.byte_en      = be;
         c.addr         = dw_addr[10:0];   // low bits of the dw address
         cpl_exp_q.push_back(c);
      end
      for (int k = 0; k < n_beats; k++) begin
         if (k == 0) begin
            b.hdr.desc    = d;
            b.hdr.payload = {pay[3], pay[2], pay[1], pay[0]};
         end else begin
            for (int i = 0; i < 8; i++) b.dw[i] = pay[(k-1)*8 + 4 + i];
         end
         send_beat(b, k == n_beats - 1, be);
      end
      gap = int'(rand_bits(2));
      if (gap != 0) begin
         @(negedge clk) cq_valid = 1'b0;
         repeat (gap - 1) @(negedge clk);
      end
   endtask

   // transmit unit answering with a four-phase ack after random delays
   initial begin
      int dly;
      cpl_ack = 1'b0;
      forever begin
         @(posedge clk);
         if (cpl_req_valid) begin
            dly = int'(rand_bits(3));
            repeat (dly) @(posedge clk);
            @(negedge clk) cpl_ack = 1'b1;
            do @(posedge clk); while (cpl_req_valid);
            dly = int'(rand_bits(3));
            repeat (dly) @(posedge clk);
            @(negedge clk) cpl_ack = 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // compare against values of the cycle that just ended
   ////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      if (rst_n) begin
         if (fifo_wr) begin
            if (fifo_exp_q.size() == 0) begin
               errors++;
               $display("FIFO write with no write payload outstanding");
            end else begin
               checks++;
               if (fifo_data !== fifo_exp_q[0]) report_err("fifo_data_o", fifo_exp_q[0], fifo_data);
               void'(fifo_exp_q.pop_front());
            end
         end
         if (cpl_req_valid && !req_prev) begin   // phase 1 seen
            if (cpl_exp_q.size() == 0) begin
               errors++;
               $display("completion request with no one-DW read outstanding");
            end else begin
               check_cpl(cpl_req, cpl_exp_q.pop_front());
            end
         end
         req_prev = cpl_req_valid;
         // throughput window with the strobe cycle counted in
         cyc_in_win++;
         if (fifo_wr) words_in_win = words_in_win + 32'd1;
         if (tput_valid) begin
            checks++;
            if (cyc_in_win != WINDOW) begin
               errors++;
               $display("throughput strobe after %0d cycles, window is %0d", cyc_in_win, WINDOW);
            end
            if (tput_count !== words_in_win)
               report_err("tput_count_o", 256'(words_in_win), 256'(tput_count));
            cyc_in_win   = 0;
            words_in_win = '0;
         end else if (cyc_in_win >= WINDOW) begin
            errors++;
            $display("throughput strobe missing at the end of a window");
            cyc_in_win   = 0;
            words_in_win = '0;
         end
      end
   end

   // watchdog sized from the packet count
   initial begin
      repeat (N_PKT * 40 + 2 * WINDOW + 50) @(posedge clk);
      $display("timeout, traffic did not drain, checks %0d errors %0d", checks, errors);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      int len;
      rst_n    = 1'b0;
      cq_valid = 1'b0;
      cq       = '0;
      repeat (5) @(posedge clk);
      @(negedge clk) rst_n = 1'b1;
      @(posedge clk);   // first cycle out of reset
      if (cq_ready !== 1'b1) report_err("cq_ready_o", 256'(1'b1), 256'(cq_ready));
      if (cpl_req_valid !== 1'b0) report_err("cpl_req_valid_o", '0, 256'(cpl_req_valid));
      if (fifo_wr !== 1'b0) report_err("fifo_wr_o", '0, 256'(fifo_wr));
      if (tput_valid !== 1'b0) report_err("tput_valid_o", '0, 256'(tput_valid));
      for (int l = 1; l <= 4; l++) send_packet(REQ_MEM_WR, l, l);   // short writes
      for (int l = 5; l <= 40; l += 5) send_packet(REQ_MEM_WR, l, l);
      repeat (8) begin
         len = 5 + int'(rand_bits(6) % 36);
         send_packet(REQ_MEM_WR, len, len);
      end
      repeat (N_RD) begin   // write queued behind each read
         send_packet(REQ_MEM_RD, 1, 0);
         len = 1 + int'(rand_bits(6) % 40);
         send_packet(REQ_MEM_WR, len, len);
      end
      send_packet(REQ_MEM_RD, 2, 0);   // dropped
      send_packet(REQ_OTHER, 12, 12);  // dropped multi-beat packet
      send_packet(REQ_MEM_WR, 7, 7);
      send_packet(REQ_MEM_RD, 1, 0);
      repeat (N_MIX) begin
         len = 1 + int'(rand_bits(6) % 40);
         if (rand_bits(2) == 32'd0) send_packet(REQ_MEM_RD, 1, 0);
         else send_packet(REQ_MEM_WR, len, len);
      end
      @(negedge clk) cq_valid = 1'b0;
      while (fifo_exp_q.size() != 0 || cpl_exp_q.size() != 0 || cpl_req_valid || cpl_ack)
         @(posedge clk);
      repeat (2 * WINDOW) @(posedge clk);   // close at least one more window
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: rx_engine.f
hw/rx_engine_pkg.sv
hw/cq_beat_capture.sv
hw/cq_request_decoder.sv
hw/cq_payload_packer.sv
hw/rx_throughput_meter.sv
hw/rx_engine.sv
verif/rx_engine_checker.sv
verif/tb_rx_engine.sv

// File: Makefile
# Verilator build and run of the receive engine testbench
VERILATOR ?= verilator
TOP       ?= tb_rx_engine
FLIST     ?= rx_engine.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS    := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	   echo "simulation ok"; \
	else \
	   echo "simulation did not pass, see $(LOG)"; \
	   exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
